// File: rtl/rtc_bus_pkg.sv
package rtc_bus_pkg;

	typedef logic [7:0] rtc_addr_t;
	typedef logic [7:0] rtc_data_t;

	//////////////////////////////////////////////////
	// Bus cycle timing in clk cycles
	//////////////////////////////////////////////////
	localparam int unsigned ADDR_CYCLES    = 4;
	localparam int unsigned TURN_CYCLES    = 1;
	localparam int unsigned DATA_CYCLES    = 4;
	localparam int unsigned RECOVER_CYCLES = 2;

	//////////////////////////////////////////////////
	// Chip register map
	//////////////////////////////////////////////////
	localparam rtc_addr_t ADDR_UPDATE = 8'hF1;
	localparam rtc_addr_t ADDR_STATUS = 8'h01;

	// Time of day
	localparam rtc_addr_t ADDR_SEC  = 8'h21;
	localparam rtc_addr_t ADDR_MIN  = 8'h22;
	localparam rtc_addr_t ADDR_HOUR = 8'h23;

	// Calendar
	localparam rtc_addr_t ADDR_DAY     = 8'h24;
	localparam rtc_addr_t ADDR_MONTH   = 8'h25;
	localparam rtc_addr_t ADDR_YEAR    = 8'h26;
	localparam rtc_addr_t ADDR_WEEKDAY = 8'h27;

	// Countdown timer
	localparam rtc_addr_t ADDR_TMR_SEC  = 8'h41;
	localparam rtc_addr_t ADDR_TMR_MIN  = 8'h42;
	localparam rtc_addr_t ADDR_TMR_HOUR = 8'h43;

	// Copies the running counters into the readable registers
	localparam rtc_data_t UPDATE_CMD = 8'h08;

	typedef enum logic [2:0] {PH_IDLE, PH_ADDR, PH_TURN, PH_DATA, PH_RECOVER} bus_phase_e;

	typedef enum logic {TXN_READ, TXN_WRITE} txn_kind_e;

endpackage

// File: rtl/rtc_host_pkg.sv
package rtc_host_pkg;

	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Read modes, each one drops at most one register group
	typedef enum logic [1:0] {
		MODE_FULL     = 2'd0,
		MODE_NO_TIME  = 2'd1,
		MODE_NO_DATE  = 2'd2,
		MODE_NO_TIMER = 2'd3
	} read_mode_e;

	//////////////////////////////////////////////////
	// Shadow slots
	// 0 status, 1..3 time, 4..7 date, 8..10 timer
	//////////////////////////////////////////////////
	localparam int unsigned NUM_SLOTS = 11;

	typedef logic [3:0] slot_idx_t;

	//////////////////////////////////////////////////
	// APB register offsets
	//////////////////////////////////////////////////
	localparam apb_addr_t REG_CTRL        = 8'h00;
	localparam apb_addr_t REG_STATUS      = 8'h04;
	localparam apb_addr_t REG_SHADOW_BASE = 8'h10;

endpackage

// File: rtl/rtc_txn_if.sv
// One chip bus transaction, scheduler to bus engine
interface rtc_txn_if import rtc_bus_pkg::*; ();

	logic      valid;
	logic      ready;
	txn_kind_e kind;
	rtc_addr_t addr;
	rtc_data_t wdata;
	logic      done;
	rtc_data_t rdata;

	modport scheduler (
		output valid, kind, addr, wdata,
		input  ready, done, rdata
	);

	modport engine (
		input  valid, kind, addr, wdata,
		output ready, done, rdata
	);

endinterface

// File: rtl/seq_ctl_if.sv
// Control, status and shadow write-back between host registers and scheduler
interface seq_ctl_if import rtc_bus_pkg::*, rtc_host_pkg::*; ();

	logic       start;
	read_mode_e mode;
	logic       busy;
	logic       pass_done;
	logic       shadow_we;
	slot_idx_t  shadow_idx;
	rtc_data_t  shadow_data;

	modport host (
		output start, mode,
		input  busy, pass_done, shadow_we, shadow_idx, shadow_data
	);

	modport seq (
		input  start, mode,
		output busy, pass_done, shadow_we, shadow_idx, shadow_data
	);

endinterface

// File: rtl/rtc_host_regs.sv
module rtc_host_regs import rtc_bus_pkg::*, rtc_host_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	seq_ctl_if.host   ctl
);

	rtc_data_t  shadow [NUM_SLOTS];
	logic       done_q;
	logic       wr_en;
	logic       ctrl_wr;
	apb_addr_t  sh_off;
	slot_idx_t  sh_idx;
	logic       sh_hit;

	// No wait states
	assign pready = 1'b1;

	assign wr_en   = psel && penable && pwrite;
	assign ctrl_wr = wr_en && (paddr == REG_CTRL) && !ctl.busy && !ctl.start;

	//////////////////////////////////////////////////
	// Control and status
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctl.start <= 1'b0;
			ctl.mode  <= MODE_FULL;
			done_q    <= 1'b0;
		end else begin
			ctl.start <= ctrl_wr && pwdata[2];
			if (ctrl_wr) begin
				ctl.mode <= read_mode_e'(pwdata[1:0]);
			end
			// Sticky until the next pass is started
			if (ctl.start) begin
				done_q <= 1'b0;
			end else if (ctl.pass_done) begin
				done_q <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Shadow register file
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				shadow[i] <= '0;
			end
		end else if (ctl.shadow_we) begin
			shadow[ctl.shadow_idx] <= ctl.shadow_data;
		end
	end

	// Shadow i sits at base + 4*i
	assign sh_off = paddr - REG_SHADOW_BASE;
	assign sh_idx = sh_off[5:2];
	assign sh_hit = (paddr >= REG_SHADOW_BASE) && (sh_off[1:0] == 2'b00)
		&& (sh_off[7:2] < 6'(NUM_SLOTS));

	// Read data during the access phase, unmapped offsets give 0
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			if (paddr == REG_STATUS) begin
				prdata = {30'b0, done_q, ctl.busy};
			end else if (sh_hit) begin
				prdata = {24'b0, shadow[sh_idx]};
			end
		end
	end

endmodule

// File: rtl/read_scheduler.sv
module read_scheduler import rtc_bus_pkg::*, rtc_host_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	seq_ctl_if.seq        ctl,
	rtc_txn_if.scheduler  txn
);

	typedef enum logic [2:0] {
		S_IDLE, S_UPDATE, S_UPDATE_WAIT, S_SELECT, S_READ, S_READ_WAIT, S_WB
	} sched_state_e;

	sched_state_e state;
	read_mode_e   mode_q;
	slot_idx_t    slot;
	logic         last_slot;

	// Slot table, from shadow index to chip register
	function automatic rtc_addr_t slot_addr(input slot_idx_t idx);
		case (idx)
			4'd0:    return ADDR_STATUS;
			4'd1:    return ADDR_SEC;
			4'd2:    return ADDR_MIN;
			4'd3:    return ADDR_HOUR;
			4'd4:    return ADDR_DAY;
			4'd5:    return ADDR_MONTH;
			4'd6:    return ADDR_YEAR;
			4'd7:    return ADDR_WEEKDAY;
			4'd8:    return ADDR_TMR_SEC;
			4'd9:    return ADDR_TMR_MIN;
			default: return ADDR_TMR_HOUR;
		endcase
	endfunction

	// Status slot is always kept
	function automatic logic slot_kept(input slot_idx_t idx, input read_mode_e m);
		case (m)
			MODE_NO_TIME:  return !(idx >= 4'd1 && idx <= 4'd3);
			MODE_NO_DATE:  return !(idx >= 4'd4 && idx <= 4'd7);
			MODE_NO_TIMER: return !(idx >= 4'd8);
			default:       return 1'b1;
		endcase
	endfunction

	assign last_slot = (slot == slot_idx_t'(NUM_SLOTS - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state           <= S_IDLE;
			mode_q          <= MODE_FULL;
			slot            <= '0;
			ctl.busy        <= 1'b0;
			ctl.pass_done   <= 1'b0;
			ctl.shadow_we   <= 1'b0;
			ctl.shadow_idx  <= '0;
			ctl.shadow_data <= '0;
			txn.valid       <= 1'b0;
			txn.kind        <= TXN_READ;
			txn.addr        <= '0;
			txn.wdata       <= '0;
		end else begin
			ctl.pass_done <= 1'b0;
			ctl.shadow_we <= 1'b0;
			case (state)
				S_IDLE: begin
					if (ctl.start) begin
						mode_q    <= ctl.mode;
						ctl.busy  <= 1'b1;
						txn.valid <= 1'b1;
						txn.kind  <= TXN_WRITE;
						txn.addr  <= ADDR_UPDATE;
						txn.wdata <= UPDATE_CMD;
						state     <= S_UPDATE;
					end
				end
				S_UPDATE: begin
					if (txn.ready) begin
						txn.valid <= 1'b0;
						state     <= S_UPDATE_WAIT;
					end
				end
				S_UPDATE_WAIT: begin
					if (txn.done) begin
						slot  <= '0;
						state <= S_SELECT;
					end
				end
				// One cycle per slot, skipped slots just advance
				S_SELECT: begin
					if (slot_kept(slot, mode_q)) begin
						txn.valid <= 1'b1;
						txn.kind  <= TXN_READ;
						txn.addr  <= slot_addr(slot);
						state     <= S_READ;
					end else if (last_slot) begin
						ctl.pass_done <= 1'b1;
						ctl.busy      <= 1'b0;
						state         <= S_IDLE;
					end else begin
						slot <= slot + 4'd1;
					end
				end
				S_READ: begin
					if (txn.ready) begin
						txn.valid <= 1'b0;
						state     <= S_READ_WAIT;
					end
				end
				S_READ_WAIT: begin
					if (txn.done) begin
						ctl.shadow_we   <= 1'b1;
						ctl.shadow_idx  <= slot;
						ctl.shadow_data <= txn.rdata;
						state           <= S_WB;
					end
				end
				S_WB: begin
					if (last_slot) begin
						ctl.pass_done <= 1'b1;
						ctl.busy      <= 1'b0;
						state         <= S_IDLE;
					end else begin
						slot  <= slot + 4'd1;
						state <= S_SELECT;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/bus_cycle_engine.sv
module bus_cycle_engine import rtc_bus_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	rtc_txn_if.engine  txn,
	output logic       rtc_ad_sel,
	output logic       rtc_cs_n,
	output logic       rtc_wr_n,
	output logic       rtc_rd_n,
	output rtc_data_t  rtc_bus_out,
	output logic       rtc_bus_oe,
	input  rtc_data_t  rtc_bus_in
);

	bus_phase_e phase;
	logic [2:0] cnt;
	txn_kind_e  kind_q;
	rtc_data_t  wdata_q;
	rtc_data_t  rdata_q;

	assign txn.ready = (phase == PH_IDLE);
	assign txn.done  = (phase == PH_RECOVER) && (cnt == 3'(RECOVER_CYCLES - 1));
	assign txn.rdata = rdata_q;

	//////////////////////////////////////////////////
	// Phase sequencing, strobes set on entry to each phase
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase       <= PH_IDLE;
			cnt         <= '0;
			kind_q      <= TXN_READ;
			rtc_ad_sel  <= 1'b0;
			rtc_cs_n    <= 1'b1;
			rtc_wr_n    <= 1'b1;
			rtc_rd_n    <= 1'b1;
			rtc_bus_oe  <= 1'b0;
			rtc_bus_out <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (txn.valid && txn.ready) begin
						phase       <= PH_ADDR;
						cnt         <= '0;
						kind_q      <= txn.kind;
						// Address goes out with wr_n low, both cases
						rtc_ad_sel  <= 1'b0;
						rtc_cs_n    <= 1'b0;
						rtc_wr_n    <= 1'b0;
						rtc_bus_oe  <= 1'b1;
						rtc_bus_out <= txn.addr;
					end
				end
				PH_ADDR: begin
					if (cnt == 3'(ADDR_CYCLES - 1)) begin
						phase      <= PH_TURN;
						cnt        <= '0;
						rtc_cs_n   <= 1'b1;
						rtc_wr_n   <= 1'b1;
						rtc_ad_sel <= 1'b1;
						rtc_bus_oe <= 1'b0;
					end else begin
						cnt <= cnt + 3'd1;
					end
				end
				PH_TURN: begin
					if (cnt == 3'(TURN_CYCLES - 1)) begin
						phase    <= PH_DATA;
						cnt      <= '0;
						rtc_cs_n <= 1'b0;
						if (kind_q == TXN_WRITE) begin
							rtc_wr_n    <= 1'b0;
							rtc_bus_oe  <= 1'b1;
							rtc_bus_out <= wdata_q;
						end else begin
							rtc_rd_n <= 1'b0;
						end
					end else begin
						cnt <= cnt + 3'd1;
					end
				end
				PH_DATA: begin
					if (cnt == 3'(DATA_CYCLES - 1)) begin
						phase      <= PH_RECOVER;
						cnt        <= '0;
						rtc_ad_sel <= 1'b0;
						rtc_cs_n   <= 1'b1;
						rtc_wr_n   <= 1'b1;
						rtc_rd_n   <= 1'b1;
						rtc_bus_oe <= 1'b0;
					end else begin
						cnt <= cnt + 3'd1;
					end
				end
				PH_RECOVER: begin
					if (cnt == 3'(RECOVER_CYCLES - 1)) begin
						phase <= PH_IDLE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 3'd1;
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// Write data and read byte
	always_ff @(posedge clk) begin
		if (txn.valid && txn.ready) begin
			wdata_q <= txn.wdata;
		end
		// Chip data is stable by the last data cycle
		if (phase == PH_DATA && cnt == 3'(DATA_CYCLES - 1) && kind_q == TXN_READ) begin
			rdata_q <= rtc_bus_in;
		end
	end

endmodule

// File: rtl/rtc_reader_top.sv
module rtc_reader_top import rtc_bus_pkg::*, rtc_host_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// APB slave
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	// Clock chip bus
	output logic      rtc_ad_sel,
	output logic      rtc_cs_n,
	output logic      rtc_wr_n,
	output logic      rtc_rd_n,
	output rtc_data_t rtc_bus_out,
	output logic      rtc_bus_oe,
	input  rtc_data_t rtc_bus_in
);

	seq_ctl_if seq_ctl ();
	rtc_txn_if txn_bus ();

	rtc_host_regs u_host_regs (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.ctl     (seq_ctl.host)
	);

	read_scheduler u_read_scheduler (
		.clk (clk),
		.rst (rst),
		.ctl (seq_ctl.seq),
		.txn (txn_bus.scheduler)
	);

	bus_cycle_engine u_bus_cycle_engine (
		.clk         (clk),
		.rst         (rst),
		.txn         (txn_bus.engine),
		.rtc_ad_sel  (rtc_ad_sel),
		.rtc_cs_n    (rtc_cs_n),
		.rtc_wr_n    (rtc_wr_n),
		.rtc_rd_n    (rtc_rd_n),
		.rtc_bus_out (rtc_bus_out),
		.rtc_bus_oe  (rtc_bus_oe),
		.rtc_bus_in  (rtc_bus_in)
	);

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int unsigned PERIOD_NS = 8
) (
	output logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: verification/rtc_chip_model.sv
module rtc_chip_model import rtc_bus_pkg::*, rtc_host_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      rtc_ad_sel,
	input  logic      rtc_cs_n,
	input  logic      rtc_wr_n,
	input  logic      rtc_rd_n,
	input  rtc_data_t rtc_bus_out,
	output rtc_data_t rtc_bus_in,
	input  rtc_data_t chip_gen,
	input  logic      log_clear
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int LOG_DEPTH = 64;

	rtc_addr_t addr_q;
	logic      cs_q;

	// Transaction log with one entry per data phase
	txn_kind_e ev_kind [LOG_DEPTH];
	rtc_addr_t ev_addr [LOG_DEPTH];
	rtc_data_t ev_data [LOG_DEPTH];
	int        ev_cnt;

	// Read data is the register address scrambled by the generation byte
	assign rtc_bus_in = rtc_rd_n ? 8'h00 : (addr_q ^ chip_gen);

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			cs_q   <= 1'b1;
			ev_cnt <= 0;
		end else begin
			cs_q <= rtc_cs_n;
			// Address phase
			if (!rtc_cs_n && !rtc_ad_sel) begin
				addr_q <= rtc_bus_out;
			end
			if (log_clear) begin
				ev_cnt <= 0;
			end else if (cs_q && !rtc_cs_n && rtc_ad_sel && ev_cnt < LOG_DEPTH) begin
				// First cycle of a data phase
				ev_kind[6'(ev_cnt)] <= rtc_wr_n ? TXN_READ : TXN_WRITE;
				ev_addr[6'(ev_cnt)] <= addr_q;
				ev_data[6'(ev_cnt)] <= rtc_bus_out;
				ev_cnt              <= ev_cnt + 1;
			end
		end
	end

endmodule

// File: verification/rtc_bus_checker.sv
module rtc_bus_checker import rtc_bus_pkg::*, rtc_host_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rtc_ad_sel,
	input logic rtc_cs_n,
	input logic rtc_wr_n,
	input logic rtc_rd_n,
	input logic rtc_bus_oe
);

	timeunit 1ns;
	timeprecision 1ps;

	a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (rst)
		!(!rtc_rd_n && !rtc_wr_n))
		else $error("rd_n and wr_n low in the same cycle");

	a_read_in_data_phase: assert property (@(posedge clk) disable iff (rst)
		!rtc_rd_n |-> !rtc_cs_n && rtc_ad_sel && !rtc_bus_oe)
		else $error("rd_n low outside a read data phase");

	// Every low stretch of cs_n lasts four cycles
	a_cs_low_width: assert property (@(posedge clk) disable iff (rst)
		$rose(rtc_cs_n) |-> !$past(rtc_cs_n, 1) && !$past(rtc_cs_n, 2)
			&& !$past(rtc_cs_n, 3) && !$past(rtc_cs_n, 4) && $past(rtc_cs_n, 5))
		else $error("cs_n low stretch is not four cycles");

	a_idle_in_reset: assert property (@(posedge clk)
		rst && $past(rst) |-> rtc_cs_n && rtc_wr_n && rtc_rd_n)
		else $error("chip strobes active during reset");

endmodule

bind rtc_reader_top rtc_bus_checker u_bus_checker (
	.clk        (clk),
	.rst        (rst),
	.rtc_ad_sel (rtc_ad_sel),
	.rtc_cs_n   (rtc_cs_n),
	.rtc_wr_n   (rtc_wr_n),
	.rtc_rd_n   (rtc_rd_n),
	.rtc_bus_oe (rtc_bus_oe)
);

// File: verification/rtc_reader_tb.sv
module rtc_reader_tb import rtc_bus_pkg::*, rtc_host_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int POLL_LIMIT = 400;

	logic      clk;
	logic      rst;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      rtc_ad_sel;
	logic      rtc_cs_n;
	logic      rtc_wr_n;
	logic      rtc_rd_n;
	rtc_data_t rtc_bus_out;
	logic      rtc_bus_oe;
	rtc_data_t rtc_bus_in;
	rtc_data_t chip_gen;
	logic      log_clear;

	// Expected shadow contents, carried from pass to pass
	apb_data_t shadow_exp [NUM_SLOTS];
	rtc_addr_t slot_table [NUM_SLOTS] = '{ADDR_STATUS, ADDR_SEC, ADDR_MIN, ADDR_HOUR,
		ADDR_DAY, ADDR_MONTH, ADDR_YEAR, ADDR_WEEKDAY, ADDR_TMR_SEC, ADDR_TMR_MIN,
		ADDR_TMR_HOUR};

	tb_clock_gen #(.PERIOD_NS(8)) u_clock_gen (.clk(clk));

	rtc_reader_top u_rtc_reader_top (.*);

	rtc_chip_model u_chip (.*);

	//////////////////////////////////////////////////
	// Failure reporting and compares
	//////////////////////////////////////////////////
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare_data(input string name, input apb_data_t exp, input apb_data_t act);
		if (act !== exp) begin
			abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic compare_addr(input string name, input rtc_addr_t exp, input rtc_addr_t act);
		if (act !== exp) begin
			abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic compare_byte(input string name, input rtc_data_t exp, input rtc_data_t act);
		if (act !== exp) begin
			abort_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic compare_kind(input string name, input txn_kind_e exp, input txn_kind_e act);
		if (act !== exp) begin
			abort_run($sformatf("MISMATCH %s: expected %s, actual %s", name, exp.name(),
				act.name()));
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	// Register group of a slot: 0 status, 1 time, 2 date, 3 timer
	function automatic int slot_group(input int i);
		if (i == 0) return 0;
		if (i <= 3) return 1;
		if (i <= 7) return 2;
		return 3;
	endfunction

	function automatic bit slot_in_pass(input int i, input read_mode_e mode);
		case (mode)
			MODE_NO_TIME:  return slot_group(i) != 1;
			MODE_NO_DATE:  return slot_group(i) != 2;
			MODE_NO_TIMER: return slot_group(i) != 3;
			default:       return 1'b1;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// APB master
	//////////////////////////////////////////////////
	task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata);
		int waited = 0;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready) begin
			if (waited == POLL_LIMIT) abort_run("APB transfer never completed, pready stayed low");
			waited++;
			@(negedge clk);
		end
		rdata = prdata;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		apb_data_t unused;
		apb_access(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
		apb_access(1'b0, addr, '0, data);
	endtask

	//////////////////////////////////////////////////
	// Pass helpers
	//////////////////////////////////////////////////
	task automatic clear_chip_log(input rtc_data_t gen);
		@(posedge clk);
		log_clear <= 1'b1;
		chip_gen  <= gen;
		@(posedge clk);
		log_clear <= 1'b0;
	endtask

	task automatic start_pass(input read_mode_e mode);
		apb_write(REG_CTRL, {29'd0, 1'b1, mode});
	endtask

	task automatic wait_pass_done(input string name);
		apb_data_t status;
		int polls = 0;
		apb_read(REG_STATUS, status);
		while (status[1] !== 1'b1) begin
			if (polls == POLL_LIMIT) abort_run({name, ": pass never finished, done stayed low"});
			polls++;
			apb_read(REG_STATUS, status);
		end
		compare_data({name, " status"}, 32'h2, status);
	endtask

	// Update write first, then one read per kept slot in slot order
	task automatic check_chip_log(input string name, input read_mode_e mode);
		int n = 1;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (slot_in_pass(i, mode)) n++;
		end
		compare_data({name, " event count"}, apb_data_t'(n), apb_data_t'(u_chip.ev_cnt));
		compare_kind({name, " update kind"}, TXN_WRITE, u_chip.ev_kind[0]);
		compare_addr({name, " update addr"}, ADDR_UPDATE, u_chip.ev_addr[0]);
		compare_byte({name, " update data"}, UPDATE_CMD, u_chip.ev_data[0]);
		n = 1;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (slot_in_pass(i, mode)) begin
				compare_kind({name, " read kind"}, TXN_READ, u_chip.ev_kind[6'(n)]);
				compare_addr({name, " read order"}, slot_table[4'(i)], u_chip.ev_addr[6'(n)]);
				n++;
			end
		end
	endtask

	task automatic check_shadows(input string name, input read_mode_e mode, input rtc_data_t gen);
		apb_data_t value;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (slot_in_pass(i, mode)) shadow_exp[4'(i)] = {24'd0, slot_table[4'(i)] ^ gen};
			apb_read(REG_SHADOW_BASE + apb_addr_t'(4 * i), value);
			compare_data($sformatf("%s shadow %0d", name, i), shadow_exp[4'(i)], value);
		end
	endtask

	task automatic run_pass(input string name, input read_mode_e mode, input rtc_data_t gen);
		clear_chip_log(gen);
		start_pass(mode);
		wait_pass_done(name);
		check_chip_log(name, mode);
		check_shadows(name, mode, gen);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic test_reset();
		apb_data_t value;
		@(negedge clk);
		compare_bit("reset cs_n", 1'b1, rtc_cs_n);
		compare_bit("reset wr_n", 1'b1, rtc_wr_n);
		compare_bit("reset rd_n", 1'b1, rtc_rd_n);
		compare_bit("reset ad_sel", 1'b0, rtc_ad_sel);
		compare_bit("reset oe", 1'b0, rtc_bus_oe);
		apb_read(REG_STATUS, value);
		compare_data("reset status", 32'h0, value);
		for (int i = 0; i < NUM_SLOTS; i++) begin
			shadow_exp[4'(i)] = '0;
			apb_read(REG_SHADOW_BASE + apb_addr_t'(4 * i), value);
			compare_data($sformatf("reset shadow %0d", i), 32'h0, value);
		end
		compare_data("reset event count", 32'h0, apb_data_t'(u_chip.ev_cnt));
	endtask

	task automatic test_skip_modes();
		run_pass("no time", MODE_NO_TIME, 8'hC3);
		run_pass("no date", MODE_NO_DATE, 8'h17);
		run_pass("no timer", MODE_NO_TIMER, 8'hE8);
	endtask

	task automatic test_busy();
		apb_data_t value;
		clear_chip_log(8'h96);
		start_pass(MODE_NO_DATE);
		apb_read(REG_STATUS, value);
		compare_data("busy status", 32'h1, value);
		// Restart with another mode while the pass runs
		apb_write(REG_CTRL, {29'd0, 1'b1, MODE_FULL});
		wait_pass_done("busy");
		check_chip_log("busy", MODE_NO_DATE);
		check_shadows("busy", MODE_NO_DATE, 8'h96);
		for (int c = 0; c < 40; c++) begin
			@(negedge clk);
			compare_bit("busy no extra pass", 1'b1, rtc_cs_n);
		end
	endtask

	task automatic test_random();
		read_mode_e mode;
		rtc_data_t  gen;
		for (int p = 0; p < 8; p++) begin
			mode = read_mode_e'(2'($urandom_range(0, 3)));
			gen  = 8'($urandom);
			run_pass($sformatf("random pass %0d", p), mode, gen);
		end
	endtask

	initial begin
		void'($urandom(32'h0cc0_9f1b));
		rst       = 1'b1;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		chip_gen  = '0;
		log_clear = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		run_pass("full pass", MODE_FULL, 8'h5A);
		test_skip_modes();
		test_busy();
		test_random();
		$display("All tests passed");
		$finish;
	end

endmodule

// File: all.f
rtl/rtc_bus_pkg.sv
rtl/rtc_host_pkg.sv
rtl/rtc_txn_if.sv
rtl/seq_ctl_if.sv
rtl/rtc_host_regs.sv
rtl/read_scheduler.sv
rtl/bus_cycle_engine.sv
rtl/rtc_reader_top.sv
verification/tb_clock_gen.sv
verification/rtc_chip_model.sv
verification/rtc_bus_checker.sv
verification/rtc_reader_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module rtc_reader_tb -o rtc_reader_sim \
	&& ./obj_dir/rtc_reader_sim \
	|| { echo "simulation run failed"; exit 1; }
